//--- hdl/lda_pkg.sv
package lda_pkg;

  ////////////////////
  // image and statistic sizes
  localparam int IMG_DIM         = 32;     // one 32-bit word per row
  localparam int COORD_W         = 5;
  localparam int PIXELS          = 1024;
  localparam int COUNT_W         = 11;     // holds 0 to 1024
  localparam int SUM_W           = 14;
  localparam int TOTAL_COORD_SUM = 15872;  // 32 * (0 + 1 + ... + 31)
  localparam int DIFF_W          = 27;     // signed dx, dy
  localparam int SB_W            = 54;     // signed scatter terms

  ////////////////////
  // register map, word addresses
  localparam int WB_ADR_W = 6;

  localparam logic [WB_ADR_W-1:0] ADR_ROW_LAST    = 6'd31;
  localparam logic [WB_ADR_W-1:0] ADR_CTRL        = 6'd32;  // bit 0 start
  localparam logic [WB_ADR_W-1:0] ADR_STATUS      = 6'd33;  // bit 0 busy, bit 1 done
  localparam logic [WB_ADR_W-1:0] ADR_BLACK_COUNT = 6'd34;
  localparam logic [WB_ADR_W-1:0] ADR_DX          = 6'd35;
  localparam logic [WB_ADR_W-1:0] ADR_DY          = 6'd36;
  localparam logic [WB_ADR_W-1:0] ADR_SB_XX_LO    = 6'd37;
  localparam logic [WB_ADR_W-1:0] ADR_SB_XX_HI    = 6'd38;
  localparam logic [WB_ADR_W-1:0] ADR_SB_XY_LO    = 6'd39;
  localparam logic [WB_ADR_W-1:0] ADR_SB_XY_HI    = 6'd40;
  localparam logic [WB_ADR_W-1:0] ADR_SB_YY_LO    = 6'd41;
  localparam logic [WB_ADR_W-1:0] ADR_SB_YY_HI    = 6'd42;

endpackage

//--- hdl/lda_if.sv
`timescale 1ns/1ps

// black class statistics after one scan
interface stats_if import lda_pkg::*; ();
  logic [COUNT_W-1:0] black_count;
  logic [SUM_W-1:0]   black_x_sum;
  logic [SUM_W-1:0]   black_y_sum;
  logic               stats_valid;  // single cycle pulse

  modport src (output black_count, black_x_sum, black_y_sum, stats_valid);
  modport dst (input black_count, black_x_sum, black_y_sum, stats_valid);
endinterface

// scaled mean difference and between-class scatter
interface scatter_if import lda_pkg::*; ();
  logic signed [DIFF_W-1:0] dx;
  logic signed [DIFF_W-1:0] dy;
  logic signed [SB_W-1:0]   sb_xx;
  logic signed [SB_W-1:0]   sb_xy;
  logic signed [SB_W-1:0]   sb_yy;
  logic                     calc_done;

  modport src (output dx, dy, sb_xx, sb_xy, sb_yy, calc_done);
  modport dst (input dx, dy, sb_xx, sb_xy, sb_yy, calc_done);
endinterface

//--- hdl/lda_wb_regs.sv
`timescale 1ns/1ps

module lda_wb_regs import lda_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [WB_ADR_W-1:0] wb_adr,
  input  logic [31:0]         wb_dat_w,
  output logic [31:0]         wb_dat_r,
  output logic                wb_ack,
  input  logic [COORD_W-1:0]  row_idx,
  output logic [IMG_DIM-1:0]  row_word,
  output logic                scan_start,
  stats_if.dst                stats,
  scatter_if.dst              result
);

  logic [IMG_DIM-1:0] rows [IMG_DIM];  // image, one word per row
  logic               busy;
  logic               done;
  logic [COUNT_W-1:0] count_q;
  logic [31:0]        rd_data;
  logic               req;

  // upper word of a scatter term, sign extended
  function automatic logic [31:0] sb_hi(input logic signed [SB_W-1:0] v);
    return {{(64-SB_W){v[SB_W-1]}}, v[SB_W-1:32]};
  endfunction

  assign req      = wb_cyc && wb_stb && !wb_ack;  // no second ack per strobe
  assign row_word = rows[row_idx];                // scanner read port

  ////////////////////
  // bus handshake
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
    end
    else
    begin
      wb_ack <= req;
      if (req && !wb_we)
        wb_dat_r <= rd_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < IMG_DIM; i++)
        rows[i] <= '0;
    end
    else if (req && wb_we && wb_adr <= ADR_ROW_LAST)
      rows[wb_adr[COORD_W-1:0]] <= wb_dat_w;
  end

  ////////////////////
  // control and status
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      scan_start <= 1'b0;
      busy       <= 1'b0;
      done       <= 1'b0;
      count_q    <= '0;
    end
    else
    begin
      scan_start <= 1'b0;
      if (req && wb_we && wb_adr == ADR_CTRL && wb_dat_w[0] && !busy)
      begin
        scan_start <= 1'b1;  // lines up with the ack
        busy       <= 1'b1;
        done       <= 1'b0;
      end
      else if (result.calc_done)
      begin
        busy <= 1'b0;
        done <= 1'b1;
      end
      if (stats.stats_valid)
        count_q <= stats.black_count;
    end
  end

  // readback mux
  always_comb
  begin
    rd_data = '0;
    if (wb_adr <= ADR_ROW_LAST)
      rd_data = rows[wb_adr[COORD_W-1:0]];
    else
      case (wb_adr)
        ADR_STATUS:      rd_data = {30'd0, done, busy};
        ADR_BLACK_COUNT: rd_data = {{(32-COUNT_W){1'b0}}, count_q};
        ADR_DX:          rd_data = {{(32-DIFF_W){result.dx[DIFF_W-1]}}, result.dx};
        ADR_DY:          rd_data = {{(32-DIFF_W){result.dy[DIFF_W-1]}}, result.dy};
        ADR_SB_XX_LO:    rd_data = result.sb_xx[31:0];
        ADR_SB_XX_HI:    rd_data = sb_hi(result.sb_xx);
        ADR_SB_XY_LO:    rd_data = result.sb_xy[31:0];
        ADR_SB_XY_HI:    rd_data = sb_hi(result.sb_xy);
        ADR_SB_YY_LO:    rd_data = result.sb_yy[31:0];
        ADR_SB_YY_HI:    rd_data = sb_hi(result.sb_yy);
        default:         rd_data = '0;  // ctrl and unmapped
      endcase
  end

endmodule

//--- hdl/class_accum.sv
`timescale 1ns/1ps

module class_accum import lda_pkg::*; (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               scan_start,
  input  logic [IMG_DIM-1:0] row_word,
  output logic [COORD_W-1:0] row_idx,
  stats_if.src               stats
);

  logic [2*COORD_W-1:0] pix_q;     // {row, column}
  logic                 scanning;
  logic [COORD_W-1:0]   col;
  logic                 black;

  assign row_idx = pix_q[2*COORD_W-1:COORD_W];  // x coordinate
  assign col     = pix_q[COORD_W-1:0];          // y coordinate
  assign black   = !row_word[col];              // 0 bit is the black class

  ////////////////////
  // row-major scan, one pixel per clock
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pix_q             <= '0;
      scanning          <= 1'b0;
      stats.stats_valid <= 1'b0;
      stats.black_count <= '0;
      stats.black_x_sum <= '0;
      stats.black_y_sum <= '0;
    end
    else
    begin
      stats.stats_valid <= 1'b0;
      if (scan_start)
      begin
        pix_q             <= '0;
        scanning          <= 1'b1;
        stats.black_count <= '0;
        stats.black_x_sum <= '0;
        stats.black_y_sum <= '0;
      end
      else if (scanning)
      begin
        pix_q <= pix_q + 1'b1;
        if (black)
        begin
          stats.black_count <= stats.black_count + 1'b1;
          stats.black_x_sum <= stats.black_x_sum + SUM_W'(row_idx);
          stats.black_y_sum <= stats.black_y_sum + SUM_W'(col);
        end
        // last pixel, sums are final next cycle
        if (&pix_q)
        begin
          scanning          <= 1'b0;
          stats.stats_valid <= 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/scatter_calc.sv
`timescale 1ns/1ps

module scatter_calc import lda_pkg::*; (
  input  logic clk,
  input  logic arst_n,
  stats_if.dst stats,
  scatter_if.src result
);

  logic                     run_q;    // product sequence active
  logic                     load_q;   // operand load cycle
  logic [2:0]               step_q;   // product 0 to 6
  logic [COUNT_W-1:0]       white_count;
  logic [SUM_W-1:0]         white_x_sum;
  logic [SUM_W-1:0]         white_y_sum;
  logic signed [DIFF_W-1:0] op_a;
  logic signed [DIFF_W-1:0] op_b;
  logic [DIFF_W-1:0]        a_abs;
  logic [DIFF_W-1:0]        b_abs;
  logic [SB_W-1:0]          mcand;
  logic [DIFF_W-1:0]        mplier;
  logic [SB_W-1:0]          acc;
  logic                     neg;
  logic signed [SB_W-1:0]   prod;
  logic signed [DIFF_W-1:0] first_q;  // first product of a dx or dy pair

  ////////////////////
  // operand select per step
  always_comb
  begin
    case (step_q)
      3'd0:    op_a = DIFF_W'(stats.black_x_sum);
      3'd1:    op_a = DIFF_W'(white_x_sum);
      3'd2:    op_a = DIFF_W'(stats.black_y_sum);
      3'd3:    op_a = DIFF_W'(white_y_sum);
      3'd6:    op_a = result.dy;
      default: op_a = result.dx;  // dx*dx and dx*dy
    endcase
    case (step_q)
      3'd0, 3'd2: op_b = DIFF_W'(white_count);
      3'd1, 3'd3: op_b = DIFF_W'(stats.black_count);
      3'd4:       op_b = result.dx;
      default:    op_b = result.dy;
    endcase
  end

  // sign and magnitude form, shift-and-add on magnitudes
  assign a_abs = op_a[DIFF_W-1] ? -op_a : op_a;
  assign b_abs = op_b[DIFF_W-1] ? -op_b : op_b;
  assign prod  = neg ? -$signed(acc) : $signed(acc);

  always_ff @(posedge clk)
  begin
    if (stats.stats_valid)
    begin
      white_count <= COUNT_W'(PIXELS) - stats.black_count;
      white_x_sum <= SUM_W'(TOTAL_COORD_SUM) - stats.black_x_sum;
      white_y_sum <= SUM_W'(TOTAL_COORD_SUM) - stats.black_y_sum;
    end
    if (load_q)
    begin
      mcand  <= SB_W'(a_abs);
      mplier <= b_abs;
      neg    <= op_a[DIFF_W-1] ^ op_b[DIFF_W-1];
      acc    <= '0;
    end
    else if (run_q && mplier != '0)
    begin
      if (mplier[0])
        acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;  // ends early once no bits are left
    end
    if (run_q && !load_q && mplier == '0 && (step_q == 3'd0 || step_q == 3'd2))
      first_q <= prod[DIFF_W-1:0];
  end

  ////////////////////
  // step sequencer
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      run_q            <= 1'b0;
      load_q           <= 1'b0;
      step_q           <= '0;
      result.calc_done <= 1'b0;
      result.dx        <= '0;
      result.dy        <= '0;
      result.sb_xx     <= '0;
      result.sb_xy     <= '0;
      result.sb_yy     <= '0;
    end
    else
    begin
      result.calc_done <= 1'b0;
      if (stats.stats_valid)
      begin
        run_q  <= 1'b1;
        load_q <= 1'b1;
        step_q <= '0;
      end
      else if (run_q && load_q)
        load_q <= 1'b0;
      else if (run_q && mplier == '0)
      begin
        case (step_q)
          3'd1:    result.dx <= first_q - $signed(prod[DIFF_W-1:0]);
          3'd3:    result.dy <= first_q - $signed(prod[DIFF_W-1:0]);
          3'd4:    result.sb_xx <= prod;
          3'd5:    result.sb_xy <= prod;
          3'd6:    result.sb_yy <= prod;
          default: ;  // first of a pair, held in first_q
        endcase
        if (step_q == 3'd6)
        begin
          run_q            <= 1'b0;
          result.calc_done <= 1'b1;
        end
        else
        begin
          step_q <= step_q + 1'b1;
          load_q <= 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/lda_top.sv
`timescale 1ns/1ps

module lda_top import lda_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [WB_ADR_W-1:0] wb_adr,
  input  logic [31:0]         wb_dat_w,
  input  logic [3:0]          wb_sel,    // full word access only
  output logic [31:0]         wb_dat_r,
  output logic                wb_ack
);

  logic [COORD_W-1:0] row_idx;
  logic [IMG_DIM-1:0] row_word;
  logic               scan_start;

  stats_if   stats ();
  scatter_if result ();

  ////////////////////
  // host port, image store and readback
  lda_wb_regs lda_wb_regs_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .row_idx    (row_idx),
    .row_word   (row_word),
    .scan_start (scan_start),
    .stats      (stats.dst),
    .result     (result.dst)
  );

  // pixel scan and black class sums
  class_accum class_accum_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .scan_start (scan_start),
    .row_word   (row_word),
    .row_idx    (row_idx),
    .stats      (stats.src)
  );

  scatter_calc scatter_calc_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .stats  (stats.dst),
    .result (result.src)
  );

endmodule

//--- tb/lda_checker.sv
`timescale 1ns/1ps

module lda_checker import lda_pkg::*; (
  input logic                clk,
  input logic                arst_n,
  input logic                wb_we,
  input logic [WB_ADR_W-1:0] wb_adr,
  input logic [31:0]         wb_dat_w,
  input logic [31:0]         wb_dat_r,
  input logic                wb_ack
);

  localparam int SCAN_CLKS = PIXELS + 1;                        // start to stats_valid
  localparam int DONE_CLKS = SCAN_CLKS + 7 * (DIFF_W + 2) + 8;  // seven products at one bit per clock

  logic [31:0] img [IMG_DIM];  // image as the host wrote it
  logic [31:0] exp_res [9];    // count, dx, dy, then lo and hi of each scatter term
  logic        busy_m;         // between an accepted start and done
  logic        done_m;
  logic        ack_q;
  string       test_name = "none";
  int          test_errs = 0;
  int          err_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cyc_count = 0;
  int          start_cyc = 0;

  // class sums straight from the pixel rules with white sums counted apart
  function automatic void mean_difference(input logic [31:0] im [IMG_DIM], output longint cnt,
                                          output longint dx, output longint dy);
    longint nb;
    longint nw;
    longint bx;
    longint by;
    longint wx;
    longint wy;
    nb = 0;
    nw = 0;
    bx = 0;
    by = 0;
    wx = 0;
    wy = 0;
    for (longint i = 0; i < IMG_DIM; i++)
      for (longint j = 0; j < IMG_DIM; j++)
        if (im[i][j])
        begin
          nw++;
          wx += i;
          wy += j;
        end
        else
        begin
          nb++;
          bx += i;
          by += j;
        end
    cnt = nb;
    dx  = bx * nw - wx * nb;  // cross-multiplied mean difference
    dy  = by * nw - wy * nb;
  endfunction

  task automatic load_expected();
    longint cnt;
    longint dx;
    longint dy;
    longint sxx;
    longint sxy;
    longint syy;
    mean_difference(img, cnt, dx, dy);
    sxx = dx * dx;
    sxy = dx * dy;
    syy = dy * dy;
    exp_res[0] = cnt[31:0];
    exp_res[1] = dx[31:0];
    exp_res[2] = dy[31:0];
    exp_res[3] = sxx[31:0];
    exp_res[4] = sxx[63:32];
    exp_res[5] = sxy[31:0];
    exp_res[6] = sxy[63:32];
    exp_res[7] = syy[31:0];
    exp_res[8] = syy[63:32];
  endtask

  task automatic note_failure(input string msg);
    $display("%s: %s", test_name, msg);
    test_errs++;
  endtask

  task automatic compare(input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("ERR %s adr %0d: expected %h, actual %h", test_name, wb_adr, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_latency(input int clks);
    if (clks < SCAN_CLKS || clks > DONE_CLKS)
      note_failure($sformatf("done came %0d clocks after start and not within %0d to %0d",
                             clks, SCAN_CLKS, DONE_CLKS));
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    err_count += test_errs;
    if (test_errs == 0)
      $display("test %s: ok", test_name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, test_errs);
    end
  endtask

  ////////////////////
  // one completed access per ack
  task automatic check_access();
    if (wb_we)
    begin
      if (wb_adr <= ADR_ROW_LAST)
        img[wb_adr[COORD_W-1:0]] = wb_dat_w;
      else if (wb_adr == ADR_CTRL && wb_dat_w[0] && !busy_m)
      begin
        busy_m    = 1'b1;  // a start while busy leaves the snapshot alone
        done_m    = 1'b0;
        start_cyc = cyc_count;
        load_expected();
      end
    end
    else if (wb_adr <= ADR_ROW_LAST)
      compare(img[wb_adr[COORD_W-1:0]], wb_dat_r);
    else if (wb_adr == ADR_STATUS && busy_m && wb_dat_r == 32'd2)
    begin
      busy_m = 1'b0;
      done_m = 1'b1;
      check_latency(cyc_count - start_cyc);
    end
    else if (wb_adr == ADR_STATUS)
      compare(busy_m ? 32'd1 : {30'd0, done_m, 1'b0}, wb_dat_r);
    else if (wb_adr >= ADR_BLACK_COUNT && wb_adr <= ADR_SB_YY_HI)
      compare(exp_res[wb_adr - ADR_BLACK_COUNT], wb_dat_r);
    else
      compare(32'd0, wb_dat_r);  // ctrl and unmapped
  endtask

  always @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      for (int i = 0; i < IMG_DIM; i++)
        img[i] = '0;
      for (int i = 0; i < 9; i++)
        exp_res[i] = '0;
      busy_m = 1'b0;
      done_m = 1'b0;
      ack_q  = 1'b0;
    end
    else
    begin
      cyc_count++;
      if (wb_ack && ack_q)
        note_failure("ack stayed high for a second cycle");
      ack_q = wb_ack;
      if (wb_ack)
        check_access();
    end
  end

endmodule

//--- tb/tb_lda.sv
`timescale 1ns/1ps

module tb_lda import lda_pkg::*; ();

  localparam int NUM_TESTS  = 9;
  localparam int CLK_PERIOD = 100;
  localparam int TEST_CLKS  = 1200 + 64 * 5 + 200;

  logic                clk;
  logic                arst_n;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [WB_ADR_W-1:0] wb_adr;
  logic [31:0]         wb_dat_w;
  logic [3:0]          wb_sel;
  logic [31:0]         wb_dat_r;
  logic                wb_ack;
  logic [31:0]         image [IMG_DIM];

  lda_top lda_top_inst (.*);

  lda_checker chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(NUM_TESTS * TEST_CLKS * CLK_PERIOD);
    $display("watchdog: the tests did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////
  // bus master driving inputs on the falling edge
  task automatic bus_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waits;
    waits = 0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack && waits < 8)
    begin
      @(negedge clk);
      waits++;
    end
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;  // address and data stay until the next access
    wb_stb = 1'b0;
    if (!wb_ack)
      chk.note_failure($sformatf("no ack for access to address %0d", adr));
  endtask

  task automatic write_word(input logic [WB_ADR_W-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic read_word(input logic [WB_ADR_W-1:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'd0, data);
  endtask

  task automatic load_image();
    for (int i = 0; i < IMG_DIM; i++)
      write_word(WB_ADR_W'(i), image[i]);
  endtask

  task automatic wait_done();
    logic [31:0] status;
    int          polls;
    polls  = 0;
    status = '0;
    while (!status[1] && polls < 1000)
    begin
      read_word(ADR_STATUS, status);
      polls++;
    end
    if (!status[1])
      chk.note_failure("done never came after start");
  endtask

  task automatic read_results();
    logic [31:0] data;
    for (int a = ADR_BLACK_COUNT; a <= ADR_SB_YY_HI; a++)
      read_word(WB_ADR_W'(a), data);
  endtask

  task automatic image_test(input string name);
    chk.begin_test(name);
    load_image();
    write_word(ADR_CTRL, 32'd1);
    wait_done();
    read_results();
    finish_test();
  endtask

  // last ack reaches the checker on the next rising edge
  task automatic finish_test();
    @(negedge clk);
    chk.end_test();
  endtask

  task automatic apply_reset();
    @(negedge clk);
    arst_n = 1'b0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;
  endtask

  initial
  begin
    logic [31:0] data;
    void'($urandom(32'ha658_93bd));
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    wb_sel   = 4'hf;
    arst_n   = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    chk.begin_test("row_readback");
    for (int i = 0; i < IMG_DIM; i++)
      image[i] = $urandom;
    load_image();
    for (int i = 0; i < IMG_DIM; i++)
      read_word(WB_ADR_W'(i), data);
    read_word(6'd63, data);  // unmapped
    finish_test();

    for (int i = 0; i < IMG_DIM; i++)
      image[i] = 32'((64'd1 << (i + 1)) - 1);  // lower triangle with bits 0 to i white
    image_test("triangle");
    for (int i = 0; i < IMG_DIM; i++)
      image[i] = 32'd0;
    image_test("all_black");
    for (int i = 0; i < IMG_DIM; i++)
      image[i] = 32'hffff_ffff;
    image_test("all_white");
    for (int k = 0; k < 3; k++)
    begin
      for (int i = 0; i < IMG_DIM; i++)
        image[i] = $urandom;
      image_test($sformatf("random_image_%0d", k));
    end

    chk.begin_test("start_while_busy");
    for (int i = 0; i < IMG_DIM; i++)
      image[i] = $urandom & $urandom;  // mostly black
    load_image();
    write_word(ADR_CTRL, 32'd1);
    repeat (900) @(negedge clk);  // late in the scan
    write_word(ADR_CTRL, 32'd1);  // a restart here would delay done
    wait_done();
    read_results();
    finish_test();

    chk.begin_test("after_reset");
    apply_reset();
    read_word(ADR_STATUS, data);
    read_results();
    read_word(6'd0, data);
    finish_test();

    $display("tests run %0d, failed %0d, errors %0d",
             chk.tests_run, chk.tests_failed, chk.err_count);
    if (chk.err_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- verilog.f
hdl/lda_pkg.sv
hdl/lda_if.sv
hdl/lda_wb_regs.sv
hdl/class_accum.sv
hdl/scatter_calc.sv
hdl/lda_top.sv
tb/lda_checker.sv
tb/tb_lda.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_lda -o tb_lda_sim \
  && ./obj_dir/tb_lda_sim | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
